//--- rtl/crPkg.sv
// Types shared by the dual-lane control register block
// Register ids are 5 bits wide; codes not listed here are legal and read as zero
// Address-sized registers are cut to addrWidth inside the banks, not by these types
package crPkg;

	localparam int idWidth = 5;

	// Lane SR comes out of reset with bit 30 set
	localparam logic [63:0] srResetValue = 64'h0000_0000_4000_0000;

	// Control register identifiers
	typedef enum logic [idWidth-1:0]
	{
		SR   = 5'h00,	// Status, per lane
		EXSR = 5'h01,	// Exception status, shared
		PC   = 5'h02,	// Reads return the synthesized PC
		LR   = 5'h03,
		VBR  = 5'h04,	// Vector base, shared
		SPC  = 5'h05,	// Saved PC
		SSP  = 5'h06,	// Saved stack pointer
		GBR  = 5'h07,
		TBR  = 5'h08,
		TEA  = 5'h09,	// Trap address, shared
		MMCR = 5'h0A,	// Only with the MMU
		KRR  = 5'h0B,	// Only with the MMU
		IMM  = 5'h1E,	// Immediate slot, reads zero
		ZZR  = 5'h1F	// Zero register
	} crId;

	// One EX3 write port
	typedef struct packed
	{
		crId         id;
		logic [63:0] value;
		logic        flush;	// EX3 flushed, drop the write
	} crWrite;

	// Private registers of one lane
	// Also used for the trap-side inputs, where gbr and tbr are unused
	typedef struct packed
	{
		logic [63:0] pc;
		logic [63:0] lr;
		logic [63:0] sr;
		logic [63:0] spc;
		logic [63:0] ssp;
		logic [63:0] gbr;
		logic [63:0] tbr;
	} crLaneRegs;

	// Registers shared by both lanes
	// As an input only exsr and tea are taken
	typedef struct packed
	{
		logic [63:0] exsr;
		logic [63:0] vbr;
		logic [63:0] tea;
		logic [63:0] mmcr;
		logic [63:0] krr;
	} crSharedRegs;

	// True when the port writes this register and is not flushed
	function automatic logic writeHit(input crWrite w, input crId id);
		return !w.flush && (w.id == id);
	endfunction

endpackage

//--- rtl/crLaneBank.sv
// Private control registers of one lane
// PC, SPC, SSP, GBR and TBR store only addrWidth bits; upper bits read as zero
// A write to PC has no effect, PC always follows the fetch side
// Writes during hold are lost
module crLaneBank #(
	parameter int addrWidth = 48
)(
	input  logic             clock,
	input  logic             reset,
	input  logic             hold,
	input  crPkg::crWrite    write,
	input  crPkg::crLaneRegs laneIn,
	output crPkg::crLaneRegs regs
);

	logic [63:0]          srReg;
	logic [63:0]          lrReg;
	logic [addrWidth-1:0] pcReg;
	logic [addrWidth-1:0] spcReg;
	logic [addrWidth-1:0] sspReg;
	logic [addrWidth-1:0] gbrReg;
	logic [addrWidth-1:0] tbrReg;

	logic hitSr;
	logic hitLr;
	logic hitSpc;
	logic hitSsp;
	logic hitGbr;
	logic hitTbr;

	logic [addrWidth-1:0] writeAddr;	// Write value cut to address size

	// Write decode, only this lane's own registers
	assign hitSr  = crPkg::writeHit(write, crPkg::SR);
	assign hitLr  = crPkg::writeHit(write, crPkg::LR);
	assign hitSpc = crPkg::writeHit(write, crPkg::SPC);
	assign hitSsp = crPkg::writeHit(write, crPkg::SSP);
	assign hitGbr = crPkg::writeHit(write, crPkg::GBR);
	assign hitTbr = crPkg::writeHit(write, crPkg::TBR);

	assign writeAddr = write.value[addrWidth-1:0];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			srReg  <= crPkg::srResetValue;
			lrReg  <= '0;
			pcReg  <= '0;
			spcReg <= '0;
			sspReg <= '0;
			gbrReg <= '0;
			tbrReg <= '0;
		end
		else if (!hold)
		begin
			// Trap-owned, load the incoming value unless written
			srReg  <= hitSr ? write.value : laneIn.sr;
			lrReg  <= hitLr ? write.value : laneIn.lr;
			spcReg <= hitSpc ? writeAddr : laneIn.spc[addrWidth-1:0];
			sspReg <= hitSsp ? writeAddr : laneIn.ssp[addrWidth-1:0];

			pcReg  <= laneIn.pc[addrWidth-1:0];

			// Software-owned, keep unless written
			if (hitGbr)
				gbrReg <= writeAddr;
			if (hitTbr)
				tbrReg <= writeAddr;
		end
	end

	// Zero-extend the address registers
	always_comb
	begin
		regs.pc  = 64'(pcReg);
		regs.lr  = lrReg;
		regs.sr  = srReg;
		regs.spc = 64'(spcReg);
		regs.ssp = 64'(sspReg);
		regs.gbr = 64'(gbrReg);
		regs.tbr = 64'(tbrReg);
	end

endmodule

//--- rtl/crSharedBank.sv
// Shared control registers and the read ports of both lanes
// Same-cycle writes to one register: lane 2 wins as it is later in program order
// Reads are combinational and see the value before any write in the same cycle
// With enableMmu at 0, MMCR and KRR are not stored and read as zero
module crSharedBank #(
	parameter int addrWidth = 48,
	parameter bit enableMmu = 1'b1
)(
	input  logic               clock,
	input  logic               reset,
	input  logic               hold,
	input  crPkg::crWrite      write1,
	input  crPkg::crWrite      write2,
	input  crPkg::crSharedRegs sharedIn,
	input  crPkg::crLaneRegs   lane1,
	input  crPkg::crLaneRegs   lane2,
	input  crPkg::crId         readId1,
	input  crPkg::crId         readId2,
	input  logic [63:0]        pcNow1,
	input  logic [63:0]        pcNow2,
	output crPkg::crSharedRegs regs,
	output logic [63:0]        readValue1,
	output logic [63:0]        readValue2
);

	logic [63:0]          exsrReg;
	logic [63:0]          teaReg;
	logic [addrWidth-1:0] vbrReg;
	logic [63:0]          mmcrReg;
	logic [63:0]          krrReg;

	logic [63:0] exsrNext;
	logic [63:0] teaNext;
	logic [63:0] vbrNext;
	logic [63:0] mmcrNext;
	logic [63:0] krrNext;

	// Merge both write ports for one register, lane 2 first
	function automatic logic [63:0] mergeWrite(
		input crPkg::crWrite w1,
		input crPkg::crWrite w2,
		input crPkg::crId    id,
		input logic [63:0]   keep
	);
		if (crPkg::writeHit(w2, id))
			return w2.value;
		else if (crPkg::writeHit(w1, id))
			return w1.value;
		return keep;
	endfunction

	// Read mux for one lane
	function automatic logic [63:0] readSelect(
		input crPkg::crId         id,
		input crPkg::crLaneRegs   lane,
		input crPkg::crSharedRegs shared,
		input logic [63:0]        pcNow
	);
		case (id)
			crPkg::SR:   return lane.sr;
			crPkg::EXSR: return shared.exsr;
			crPkg::PC:   return 64'(pcNow[addrWidth-1:0]);	// Synthesized PC, not the register
			crPkg::LR:   return lane.lr;
			crPkg::VBR:  return shared.vbr;
			crPkg::SPC:  return lane.spc;
			crPkg::SSP:  return lane.ssp;
			crPkg::GBR:  return lane.gbr;
			crPkg::TBR:  return lane.tbr;
			crPkg::TEA:  return shared.tea;
			crPkg::MMCR: return enableMmu ? shared.mmcr : 64'd0;
			crPkg::KRR:  return enableMmu ? shared.krr : 64'd0;
			default:     return 64'd0;	// IMM, ZZR and unused codes
		endcase
	endfunction

	// EXSR and TEA fall back to the trap side, the rest hold
	assign exsrNext = mergeWrite(write1, write2, crPkg::EXSR, sharedIn.exsr);
	assign teaNext  = mergeWrite(write1, write2, crPkg::TEA, sharedIn.tea);
	assign vbrNext  = mergeWrite(write1, write2, crPkg::VBR, 64'(vbrReg));
	assign mmcrNext = mergeWrite(write1, write2, crPkg::MMCR, mmcrReg);
	assign krrNext  = mergeWrite(write1, write2, crPkg::KRR, krrReg);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			exsrReg <= '0;
			teaReg  <= '0;
			vbrReg  <= '0;
		end
		else if (!hold)
		begin
			exsrReg <= exsrNext;
			teaReg  <= teaNext;
			vbrReg  <= vbrNext[addrWidth-1:0];	// Address-sized
		end
	end

	generate
		if (enableMmu)
		begin : gMmu
			always_ff @(posedge clock)
			begin
				if (reset)
				begin
					mmcrReg <= '0;
					krrReg  <= '0;
				end
				else if (!hold)
				begin
					mmcrReg <= mmcrNext;
					krrReg  <= krrNext;
				end
			end
		end
		else
		begin : gNoMmu
			// No MMU, nothing stored
			assign mmcrReg = '0;
			assign krrReg  = '0;
		end
	endgenerate

	always_comb
	begin
		regs.exsr = exsrReg;
		regs.vbr  = 64'(vbrReg);
		regs.tea  = teaReg;
		regs.mmcr = mmcrReg;
		regs.krr  = krrReg;
	end

	// Same-cycle reads, no forwarding from EX stages
	always_comb
	begin
		readValue1 = readSelect(readId1, lane1, regs, pcNow1);
		readValue2 = readSelect(readId2, lane2, regs, pcNow2);
	end

endmodule

//--- rtl/controlRegs2w.sv
// Control registers of a dual-issue core, one EX3 write port per lane
// addrWidth sets the stored bits of PC, SPC, SSP, GBR, TBR and VBR (48 or 32)
// enableMmu at 0 removes MMCR and KRR; hold freezes every register
module controlRegs2w #(
	parameter int addrWidth = 48,
	parameter bit enableMmu = 1'b1
)(
	input  logic               clock,
	input  logic               reset,
	input  logic               hold,

	input  crPkg::crWrite      write1,		// Lane 1 EX3
	input  crPkg::crWrite      write2,		// Lane 2 EX3

	input  crPkg::crId         readId1,
	input  crPkg::crId         readId2,

	input  logic [63:0]        pcNow1,		// Synthesized PC from fetch
	input  logic [63:0]        pcNow2,

	input  crPkg::crLaneRegs   laneIn1,		// Trap-side values
	input  crPkg::crLaneRegs   laneIn2,
	input  crPkg::crSharedRegs sharedIn,

	output crPkg::crLaneRegs   laneRegs1,
	output crPkg::crLaneRegs   laneRegs2,
	output crPkg::crSharedRegs sharedRegs,

	output logic [63:0]        readValue1,
	output logic [63:0]        readValue2
);

	crLaneBank #(
		.addrWidth(addrWidth)
	) lane1Bank (
		.clock  (clock),
		.reset  (reset),
		.hold   (hold),
		.write  (write1),
		.laneIn (laneIn1),
		.regs   (laneRegs1)
	);

	crLaneBank #(
		.addrWidth(addrWidth)
	) lane2Bank (
		.clock  (clock),
		.reset  (reset),
		.hold   (hold),
		.write  (write2),
		.laneIn (laneIn2),
		.regs   (laneRegs2)
	);

	// Shared registers and both read ports
	crSharedBank #(
		.addrWidth(addrWidth),
		.enableMmu(enableMmu)
	) sharedBank (
		.clock      (clock),
		.reset      (reset),
		.hold       (hold),
		.write1     (write1),
		.write2     (write2),
		.sharedIn   (sharedIn),
		.lane1      (laneRegs1),
		.lane2      (laneRegs2),
		.readId1    (readId1),
		.readId2    (readId2),
		.pcNow1     (pcNow1),
		.pcNow2     (pcNow2),
		.regs       (sharedRegs),
		.readValue1 (readValue1),
		.readValue2 (readValue2)
	);

endmodule

//--- test/controlRegsTb.sv
// Testbench for controlRegs2w with default parameters (addrWidth 48, MMU present)
// Inputs change on the falling edge and register outputs are checked at the next one
// Reads are checked 1 ns after the inputs change, before the rising edge
module controlRegsTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [63:0] addrMask = 64'h0000_FFFF_FFFF_FFFF;	// 48 stored bits
	localparam logic [63:0] srAfterReset = 64'h0000_0000_4000_0000;

	logic clock;
	logic reset;
	logic hold;
	crPkg::crWrite write1;
	crPkg::crWrite write2;
	crPkg::crId readId1;
	crPkg::crId readId2;
	logic [63:0] pcNow1;
	logic [63:0] pcNow2;
	crPkg::crLaneRegs laneIn1;
	crPkg::crLaneRegs laneIn2;
	crPkg::crSharedRegs sharedIn;
	crPkg::crLaneRegs laneRegs1;
	crPkg::crLaneRegs laneRegs2;
	crPkg::crSharedRegs sharedRegs;
	logic [63:0] readValue1;
	logic [63:0] readValue2;

	// Reference model state
	crPkg::crLaneRegs m1;
	crPkg::crLaneRegs m2;
	crPkg::crSharedRegs ms;

	logic [63:0] lcgState = 64'd92;
	int checks = 0;
	int errors = 0;
	int testErrors = 0;
	int testNum = 0;
	int failedTests = 0;
	bit released;

	crPkg::crId laneIds[5] = '{crPkg::GBR, crPkg::TBR, crPkg::SPC, crPkg::SSP, crPkg::LR};
	crPkg::crId trapIds[4] = '{crPkg::SR, crPkg::LR, crPkg::SPC, crPkg::SSP};
	crPkg::crId sharedIds[3] = '{crPkg::VBR, crPkg::MMCR, crPkg::KRR};

	controlRegs2w controlRegs2w_inst (
		.clock(clock), .reset(reset), .hold(hold),
		.write1(write1), .write2(write2),
		.readId1(readId1), .readId2(readId2),
		.pcNow1(pcNow1), .pcNow2(pcNow2),
		.laneIn1(laneIn1), .laneIn2(laneIn2), .sharedIn(sharedIn),
		.laneRegs1(laneRegs1), .laneRegs2(laneRegs2), .sharedRegs(sharedRegs),
		.readValue1(readValue1), .readValue2(readValue2)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial
	begin
		reset = 1'b1;
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

	function automatic logic [63:0] nextRand();
		lcgState = lcgState * 64'd6364136223846793005 + 64'd1442695040888963407;
		return lcgState;
	endfunction

	function automatic int randBelow(int n);
		logic [63:0] r;
		r = nextRand();
		return int'(r[62:32]) % n;	// High bits as the low ones repeat quickly
	endfunction

	function automatic crPkg::crWrite makeWrite(crPkg::crId id, logic [63:0] value, logic flush);
		crPkg::crWrite w;
		w.id = id;
		w.value = value;
		w.flush = flush;
		return w;
	endfunction

	function automatic crPkg::crLaneRegs laneNext(crPkg::crLaneRegs cur, crPkg::crWrite w,
		crPkg::crLaneRegs inp);
		crPkg::crLaneRegs n;
		n = cur;	// GBR and TBR keep
		n.pc = inp.pc & addrMask;
		n.lr = inp.lr;
		n.sr = inp.sr;
		n.spc = inp.spc & addrMask;
		n.ssp = inp.ssp & addrMask;
		if (!w.flush)
			case (w.id)
				crPkg::SR:  n.sr = w.value;
				crPkg::LR:  n.lr = w.value;
				crPkg::SPC: n.spc = w.value & addrMask;
				crPkg::SSP: n.ssp = w.value & addrMask;
				crPkg::GBR: n.gbr = w.value & addrMask;
				crPkg::TBR: n.tbr = w.value & addrMask;
				default: ;
			endcase
		return n;
	endfunction

	function automatic crPkg::crSharedRegs sharedApply(crPkg::crSharedRegs cur, crPkg::crWrite w);
		crPkg::crSharedRegs n;
		n = cur;
		if (!w.flush)
			case (w.id)
				crPkg::EXSR: n.exsr = w.value;
				crPkg::VBR:  n.vbr = w.value & addrMask;
				crPkg::TEA:  n.tea = w.value;
				crPkg::MMCR: n.mmcr = w.value;
				crPkg::KRR:  n.krr = w.value;
				default: ;
			endcase
		return n;
	endfunction

	function automatic logic [63:0] modelRead(crPkg::crId id, crPkg::crLaneRegs lane,
		crPkg::crSharedRegs sh, logic [63:0] pcNow);
		case (id)
			crPkg::SR:   return lane.sr;
			crPkg::EXSR: return sh.exsr;
			crPkg::PC:   return pcNow & addrMask;
			crPkg::LR:   return lane.lr;
			crPkg::VBR:  return sh.vbr;
			crPkg::SPC:  return lane.spc;
			crPkg::SSP:  return lane.ssp;
			crPkg::GBR:  return lane.gbr;
			crPkg::TBR:  return lane.tbr;
			crPkg::TEA:  return sh.tea;
			crPkg::MMCR: return sh.mmcr;
			crPkg::KRR:  return sh.krr;
			default:     return 64'd0;
		endcase
	endfunction

	always @(posedge clock)
	begin
		if (reset)
		begin
			m1 = '0;
			m2 = '0;
			m1.sr = srAfterReset;
			m2.sr = srAfterReset;
			ms = '0;
		end
		else if (!hold)
		begin
			m1 = laneNext(m1, write1, laneIn1);
			m2 = laneNext(m2, write2, laneIn2);
			ms.exsr = sharedIn.exsr;
			ms.tea = sharedIn.tea;
			ms = sharedApply(sharedApply(ms, write1), write2);	// Lane 2 applied last
		end
	end

	task automatic checkValue(string name, logic [63:0] got, logic [63:0] expected);
		checks++;
		assert (got === expected)
		else
		begin
			$display("[FAIL] %s got %h expected %h", name, got, expected);
			errors++;
			testErrors++;
		end
	endtask

	task automatic checkLane(string who, crPkg::crLaneRegs got, crPkg::crLaneRegs expected);
		checkValue({who, ".pc"}, got.pc, expected.pc);
		checkValue({who, ".lr"}, got.lr, expected.lr);
		checkValue({who, ".sr"}, got.sr, expected.sr);
		checkValue({who, ".spc"}, got.spc, expected.spc);
		checkValue({who, ".ssp"}, got.ssp, expected.ssp);
		checkValue({who, ".gbr"}, got.gbr, expected.gbr);
		checkValue({who, ".tbr"}, got.tbr, expected.tbr);
	endtask

	task automatic checkShared(string who, crPkg::crSharedRegs got, crPkg::crSharedRegs expected);
		checkValue({who, ".exsr"}, got.exsr, expected.exsr);
		checkValue({who, ".vbr"}, got.vbr, expected.vbr);
		checkValue({who, ".tea"}, got.tea, expected.tea);
		checkValue({who, ".mmcr"}, got.mmcr, expected.mmcr);
		checkValue({who, ".krr"}, got.krr, expected.krr);
	endtask

	task automatic checkRegs();
		checkLane("laneRegs1", laneRegs1, m1);
		checkLane("laneRegs2", laneRegs2, m2);
		checkShared("sharedRegs", sharedRegs, ms);
	endtask

	task automatic checkReads();
		checkValue("readValue1", readValue1, modelRead(readId1, m1, ms, pcNow1));
		checkValue("readValue2", readValue2, modelRead(readId2, m2, ms, pcNow2));
	endtask

	// Runs one clock from the falling edge that set the inputs
	task automatic step();
		#1;
		checkReads();	// Pre-edge values
		@(posedge clock);
		@(negedge clock);
		checkRegs();
	endtask

	task automatic randomInputs();
		laneIn1 = {nextRand(), nextRand(), nextRand(), nextRand(),
			nextRand(), nextRand(), nextRand()};
		laneIn2 = {nextRand(), nextRand(), nextRand(), nextRand(),
			nextRand(), nextRand(), nextRand()};
		sharedIn = {nextRand(), nextRand(), nextRand(), nextRand(), nextRand()};
		pcNow1 = nextRand();
		pcNow2 = nextRand();
	endtask

	function automatic crPkg::crId anyId();
		return crPkg::crId'(5'(randBelow(12)));
	endfunction

	task automatic startTest();
		testNum++;
		testErrors = 0;
	endtask

	task automatic finishTest(string name);
		if (testErrors == 0)
			$display("test %0d %s: ok", testNum, name);
		else
		begin
			$display("test %0d %s: %0d errors", testNum, name, testErrors);
			failedTests++;
		end
	endtask

	task automatic waitResetRelease(output bit ok);
		ok = 1'b0;
		for (int n = 0; n < 20 && !ok; n++)
		begin
			@(posedge clock);
			if (!reset)
				ok = 1'b1;
		end
		if (ok)
			@(negedge clock);
	endtask

	task automatic runTests();
		crPkg::crLaneRegs snap1;
		crPkg::crLaneRegs snap2;
		crPkg::crSharedRegs snapShared;
		crPkg::crId id;
		logic [63:0] v1;
		logic [63:0] v2;
		crPkg::crId zeroIds[4];

		startTest();
		checkValue("laneRegs1.sr", laneRegs1.sr, srAfterReset);
		checkValue("laneRegs2.sr", laneRegs2.sr, srAfterReset);
		checkRegs();
		for (int i = 0; i < 32; i++)
		begin
			readId1 = crPkg::crId'(5'(i));
			readId2 = crPkg::crId'(5'(31 - i));
			step();	// Hold keeps the reset state
		end
		finishTest("reset state");

		startTest();
		hold = 1'b0;
		for (int i = 0; i < 40; i++)
		begin
			randomInputs();
			readId1 = (i % 4 == 3) ? crPkg::PC : write1.id;	// Last cycle's write
			readId2 = (i % 4 == 3) ? crPkg::PC : write2.id;
			write1 = makeWrite(laneIds[randBelow(5)], nextRand(), 1'b0);
			write2 = makeWrite(laneIds[randBelow(5)], nextRand(), 1'b0);
			step();
		end
		finishTest("lane writes and width");

		startTest();
		for (int i = 0; i < 30; i++)
		begin
			randomInputs();
			readId1 = anyId();
			readId2 = anyId();
			write1 = makeWrite(crPkg::ZZR, 64'd0, 1'b1);
			write2 = makeWrite(crPkg::ZZR, 64'd0, 1'b1);
			if (i % 3 == 1)
				write1 = makeWrite(trapIds[randBelow(4)], nextRand(), 1'b0);
			if (i % 3 == 2)
				write2 = makeWrite(trapIds[randBelow(4)], nextRand(), 1'b0);
			if (i % 5 == 0)
				write2 = makeWrite(randBelow(2) == 0 ? crPkg::EXSR : crPkg::TEA, nextRand(), 1'b0);
			step();
		end
		finishTest("incoming values versus writes");

		startTest();
		for (int i = 0; i < 10; i++)
		begin
			randomInputs();
			write1 = makeWrite(anyId(), nextRand(), 1'b1);
			write2 = makeWrite(anyId(), nextRand(), 1'b1);
			step();
		end
		snap1 = m1;
		snap2 = m2;
		snapShared = ms;
		hold = 1'b1;
		for (int i = 0; i < 6; i++)
		begin
			randomInputs();
			write1 = makeWrite(anyId(), nextRand(), 1'b0);
			write2 = makeWrite(anyId(), nextRand(), 1'b0);
			step();
			checkLane("held laneRegs1", laneRegs1, snap1);
			checkLane("held laneRegs2", laneRegs2, snap2);
			checkShared("held sharedRegs", sharedRegs, snapShared);
		end
		hold = 1'b0;
		finishTest("flush and hold");

		startTest();
		for (int i = 0; i < 30; i++)
		begin
			randomInputs();
			id = sharedIds[randBelow(3)];
			readId1 = sharedIds[randBelow(3)];
			readId2 = sharedIds[randBelow(3)];
			write1 = makeWrite(id, nextRand(), 1'b0);
			write2 = makeWrite(i % 2 == 0 ? id : sharedIds[randBelow(3)], nextRand(), 1'b0);
			step();
		end
		v1 = nextRand();
		v2 = nextRand();
		write1 = makeWrite(crPkg::VBR, v1, 1'b0);
		write2 = makeWrite(crPkg::VBR, v2, 1'b0);
		step();
		checkValue("sharedRegs.vbr", sharedRegs.vbr, v2 & addrMask);
		write1 = makeWrite(crPkg::KRR, v1, 1'b0);
		write2 = makeWrite(crPkg::KRR, v2, 1'b0);
		step();
		checkValue("sharedRegs.krr", sharedRegs.krr, v2);
		finishTest("shared writes and lane priority");

		startTest();
		zeroIds = '{crPkg::IMM, crPkg::ZZR, crPkg::crId'(5'h0C), crPkg::crId'(5'h15)};
		write1 = makeWrite(crPkg::ZZR, 64'd0, 1'b1);
		write2 = makeWrite(crPkg::ZZR, 64'd0, 1'b1);
		for (int i = 0; i < 4; i++)
		begin
			readId1 = zeroIds[i];
			readId2 = zeroIds[3 - i];
			step();
			checkValue("readValue1", readValue1, 64'd0);
			checkValue("readValue2", readValue2, 64'd0);
		end
		v1 = m1.gbr;
		v2 = m2.tbr;
		readId1 = crPkg::GBR;
		readId2 = crPkg::TBR;
		write1 = makeWrite(crPkg::GBR, ~v1, 1'b0);
		write2 = makeWrite(crPkg::TBR, ~v2, 1'b0);
		#1;
		checkValue("readValue1", readValue1, v1);	// Old value in the write cycle
		checkValue("readValue2", readValue2, v2);
		step();
		checkValue("readValue1", readValue1, ~v1 & addrMask);
		checkValue("readValue2", readValue2, ~v2 & addrMask);
		finishTest("special reads");
	endtask

	initial
	begin
		hold = 1'b1;	// Keeps the reset state until test 1 has looked at it
		write1 = makeWrite(crPkg::ZZR, 64'd0, 1'b1);
		write2 = makeWrite(crPkg::ZZR, 64'd0, 1'b1);
		readId1 = crPkg::ZZR;
		readId2 = crPkg::ZZR;
		pcNow1 = '0;
		pcNow2 = '0;
		laneIn1 = '0;
		laneIn2 = '0;
		sharedIn = '0;
		waitResetRelease(released);
		if (!released)
		begin
			$display("reset was not released within 20 cycles");
			$display("*** FAILED ***");
		end
		else
		begin
			runTests();
			$display("tests %0d, failed %0d, checks %0d, errors %0d",
				testNum, failedTests, checks, errors);
			if (errors == 0)
				$display("*** PASSED ***");
			else
				$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- vlog.f
rtl/crPkg.sv
rtl/crLaneBank.sv
rtl/crSharedBank.sv
rtl/controlRegs2w.sv
test/controlRegsTb.sv

//--- Makefile
# Verilator build and run for the control register testbench
TOP := controlRegsTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then \
		echo "simulation reported failure"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then \
		echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
